/* list.f */
source/sdram_pkg.sv
source/sdram_sequencer.sv
source/sdram_port_select.sv
source/sdram_cmd_gen.sv
source/sdram_ctrl.sv
tb/sdram_model.sv
tb/tb_sdram_ctrl.sv

/* run.sh */
#!/bin/sh
# build and run the sdram controller testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f list.f --top-module tb_sdram_ctrl -o sim_tb &&
./obj_dir/sim_tb | grep "SIMULATION PASSED" ||
{ echo "run did not pass"; exit 1; }

/* source/sdram_cmd_gen.sv */
// sdram command generator
// drives the registered pin bus: init sequence, ACTIVE/CAS per pair with
// auto-precharge, refresh in the pair 1 slot, ack toggles and read return

`timescale 1ns/10ps

module sdram_cmd_gen (
	input  logic                  clk,
	input  logic                  init_n,
	input  sdram_pkg::phase_t     phase,
	input  logic                  init_busy,
	input  logic [4:0]            init_frame,
	input  logic                  refresh_due,
	input  sdram_pkg::pair_pick_t pick0,
	input  sdram_pkg::pair_pick_t pick1,
	input  logic                  req1,
	input  logic                  req2,
	input  sdram_pkg::host_req_t  host1,
	input  sdram_pkg::host_req_t  host2,
	input  sdram_pkg::word_t      dq_in,
	output logic                  refresh_taken,
	output logic                  hold0,
	output sdram_pkg::sdram_bus_t bus,
	output sdram_pkg::word_t      dq_out,
	output logic                  ack1,
	output logic                  ack2,
	output sdram_pkg::word_t      q1,
	output sdram_pkg::word_t      q2,
	output sdram_pkg::word_t      cpu_q,
	output sdram_pkg::word_t      gfx_q
);

	localparam sdram_pkg::phase_t RAS_SLOT  [2] = '{sdram_pkg::PH_RAS0, sdram_pkg::PH_RAS1};
	localparam sdram_pkg::phase_t CAS_SLOT  [2] = '{sdram_pkg::PH_CAS0, sdram_pkg::PH_CAS1};
	localparam sdram_pkg::phase_t READ_SLOT [2] = '{sdram_pkg::PH_READ0, sdram_pkg::PH_READ1};

	// pair-indexed views of the ports
	sdram_pkg::pair_pick_t pick [2];
	sdram_pkg::host_req_t  host [2];
	logic [1:0]            req;
	logic [1:0]            ack;
	sdram_pkg::word_t      host_q   [2];
	sdram_pkg::word_t      stream_q [2];

	sdram_pkg::src_e       take_src [2];  // pick as accepted by this slot
	logic [1:0]            ras_go;
	logic [1:0]            cas_go;
	logic [1:0]            rd_go;

	// per pair access latches
	sdram_pkg::src_e       src_q  [2];
	logic [1:0]            we_q;
	sdram_pkg::full_addr_t addr_q [2];
	sdram_pkg::mask_t      ds_q   [2];
	sdram_pkg::word_t      din_q  [2];
	sdram_pkg::word_t      sd_din;        // dq sampled every cycle
	logic                  refresh_hold;

	assign pick[0] = pick0;
	assign pick[1] = pick1;
	assign host[0] = host1;
	assign host[1] = host2;
	assign req     = {req2, req1};
	assign ack1    = ack[0];
	assign ack2    = ack[1];
	assign q1      = host_q[0];
	assign q2      = host_q[1];
	assign cpu_q   = stream_q[0];
	assign gfx_q   = stream_q[1];

	always_comb begin
		for (int p = 0; p < 2; p++) begin
			take_src[p] = pick[p].src;
			// a host read returning at this edge still looks pending, skip it
			if (pick[p].src == sdram_pkg::SRC_HOST && src_q[p] == sdram_pkg::SRC_HOST && !we_q[p])
				take_src[p] = sdram_pkg::SRC_NONE;
			ras_go[p] = !init_busy && phase == RAS_SLOT[p];
			cas_go[p] = !init_busy && phase == CAS_SLOT[p] && src_q[p] != sdram_pkg::SRC_NONE;
			rd_go[p]  = !init_busy && phase == READ_SLOT[p] && src_q[p] != sdram_pkg::SRC_NONE
				&& !we_q[p];
		end
	end

	// refresh only in the pair 1 slot with both pairs idle
	assign refresh_taken = ras_go[1] && take_src[1] == sdram_pkg::SRC_NONE && refresh_due
		&& src_q[0] == sdram_pkg::SRC_NONE;
	assign hold0 = refresh_hold | init_busy;   // keeps pair 0 off the bus during tRFC

	// ------------------------------------------------------------
	// pin bus, acks and access state
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			bus.cmd      <= sdram_pkg::CMD_NOP;
			bus.a        <= '0;
			bus.ba       <= '0;
			bus.dqm      <= 2'b11;
			bus.dq_oe    <= 1'b0;
			ack          <= '0;
			src_q        <= '{default: sdram_pkg::SRC_NONE};
			we_q         <= '0;
			refresh_hold <= 1'b0;
		end else begin
			bus.cmd   <= sdram_pkg::CMD_NOP;   // idle unless a slot fires
			bus.dqm   <= 2'b11;
			bus.dq_oe <= 1'b0;
			if (init_busy) begin
				if (phase == sdram_pkg::PH_RAS0) begin
					case (init_frame)
						sdram_pkg::INIT_PRECHARGE: begin
							bus.cmd   <= sdram_pkg::CMD_PRECHARGE;
							bus.a[10] <= 1'b1;             // all banks
						end
						sdram_pkg::INIT_REFRESH_A, sdram_pkg::INIT_REFRESH_B:
							bus.cmd <= sdram_pkg::CMD_AUTO_REFRESH;
						sdram_pkg::INIT_LOAD_MODE: begin
							bus.cmd <= sdram_pkg::CMD_LOAD_MODE;
							bus.a   <= sdram_pkg::MODE_WORD;
							bus.ba  <= '0;
						end
						default: ;
					endcase
				end
			end else begin
				for (int p = 0; p < 2; p++) begin
					if (ras_go[p]) begin
						src_q[p] <= take_src[p];
						we_q[p]  <= (take_src[p] == sdram_pkg::SRC_HOST) && host[p].we;
						if (take_src[p] != sdram_pkg::SRC_NONE) begin
							bus.cmd <= sdram_pkg::CMD_ACTIVE;
							bus.a   <= pick[p].addr[21:9];    // row
							bus.ba  <= pick[p].addr[23:22];
						end
					end
					if (cas_go[p]) begin
						bus.cmd <= we_q[p] ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
						bus.a   <= {4'b0010, addr_q[p][8:0]};   // A10 = auto precharge
						bus.ba  <= addr_q[p][23:22];
						bus.dqm <= ~ds_q[p];
						if (we_q[p]) begin
							bus.dq_oe <= 1'b1;
							ack[p]    <= req[p];   // write done once it is on the bus
						end
					end
					if (rd_go[p] && src_q[p] == sdram_pkg::SRC_HOST)
						ack[p] <= req[p];          // read data valid with this toggle
				end
				if (phase == sdram_pkg::PH_RAS1)
					refresh_hold <= refresh_taken;  // covers the next pair 0 slot only
				if (refresh_taken)
					bus.cmd <= sdram_pkg::CMD_AUTO_REFRESH;
			end
		end
	end

	// ------------------------------------------------------------
	// data path
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		sd_din <= dq_in;
		for (int p = 0; p < 2; p++) begin
			if (ras_go[p] && take_src[p] != sdram_pkg::SRC_NONE) begin
				addr_q[p] <= pick[p].addr;
				ds_q[p]   <= (take_src[p] == sdram_pkg::SRC_HOST) ? host[p].ds : 2'b11;
				din_q[p]  <= host[p].d;
			end
			if (cas_go[p] && we_q[p])
				dq_out <= din_q[p];
			if (rd_go[p]) begin
				if (src_q[p] == sdram_pkg::SRC_HOST)
					host_q[p] <= sd_din;
				else
					stream_q[p] <= sd_din;
			end
		end
	end

endmodule

/* source/sdram_ctrl.sv */
// sdram controller top
// two bank pairs in a fixed 6-cycle frame: pair 0 serves host port 1
// and the cpu stream, pair 1 serves host port 2 and the gfx stream

`timescale 1ns/10ps

module sdram_ctrl (
	input  logic                    clk,
	input  logic                    init_n,
	input  logic                    port1_req,
	output logic                    port1_ack,
	input  sdram_pkg::host_req_t    port1_host,
	output sdram_pkg::word_t        port1_q,
	input  logic                    port2_req,
	output logic                    port2_ack,
	input  sdram_pkg::host_req_t    port2_host,
	output sdram_pkg::word_t        port2_q,
	input  sdram_pkg::stream_addr_t cpu_addr,
	output sdram_pkg::word_t        cpu_q,
	input  sdram_pkg::stream_addr_t gfx_addr,
	output sdram_pkg::word_t        gfx_q,
	output sdram_pkg::sdram_bus_t   sd_bus,
	output sdram_pkg::word_t        dq_out,
	input  sdram_pkg::word_t        dq_in
);

	sdram_pkg::phase_t     phase;
	logic                  init_busy;
	logic [4:0]            init_frame;
	logic                  refresh_due;
	logic                  refresh_taken;
	logic                  hold0;
	logic                  port1_pending;
	logic                  port2_pending;
	sdram_pkg::pair_pick_t pick0;
	sdram_pkg::pair_pick_t pick1;

	assign port1_pending = port1_req ^ port1_ack;  // toggle handshake
	assign port2_pending = port2_req ^ port2_ack;

	sdram_sequencer u_sequencer (
		.clk(clk), .init_n(init_n), .phase(phase), .init_busy(init_busy),
		.init_frame(init_frame), .refresh_due(refresh_due), .refresh_taken(refresh_taken)
	);

	// pair 1 only needs holding off until init is done
	sdram_port_select #(.PAIR_BANK(1'b0)) u_select0 (
		.clk(clk), .init_n(init_n), .phase(phase), .host(port1_host),
		.host_pending(port1_pending), .stream_addr(cpu_addr), .hold(hold0), .pick(pick0)
	);

	sdram_port_select #(.PAIR_BANK(1'b1)) u_select1 (
		.clk(clk), .init_n(init_n), .phase(phase), .host(port2_host),
		.host_pending(port2_pending), .stream_addr(gfx_addr), .hold(init_busy), .pick(pick1)
	);

	sdram_cmd_gen u_cmd_gen (
		.clk(clk), .init_n(init_n), .phase(phase), .init_busy(init_busy),
		.init_frame(init_frame), .refresh_due(refresh_due), .pick0(pick0), .pick1(pick1),
		.req1(port1_req), .req2(port2_req), .host1(port1_host), .host2(port2_host),
		.dq_in(dq_in), .refresh_taken(refresh_taken), .hold0(hold0), .bus(sd_bus),
		.dq_out(dq_out), .ack1(port1_ack), .ack2(port2_ack), .q1(port1_q), .q2(port2_q),
		.cpu_q(cpu_q), .gfx_q(gfx_q)
	);

endmodule

/* source/sdram_pkg.sv */
// sdram controller shared definitions
// frame slots, init steps, pin command codes and the structs that
// pass between sequencer, port selectors, command generator and pins

package sdram_pkg;

	typedef logic [2:0]  phase_t;        // slot within the 6-cycle frame
	typedef logic [15:0] word_t;         // sdram data word
	typedef logic [1:0]  mask_t;         // byte selects, bit 1 = upper byte
	typedef logic [23:1] host_addr_t;    // host word address
	typedef logic [14:0] stream_addr_t;  // cpu/gfx word address
	typedef logic [12:0] sd_addr_t;      // multiplexed row/column pins
	typedef logic [1:0]  bank_t;
	typedef logic [23:0] full_addr_t;    // bank[23:22] row[21:9] col[8:0]

	// ------------------------------------------------------------
	// timing and mode
	// ------------------------------------------------------------
	localparam phase_t     RASCAS_DELAY = 3'd2;  // tRCD, 2 cycles below 100 MHz
	localparam logic [2:0] CAS_LATENCY  = 3'd2;
	localparam phase_t     FRAME_LEN    = 3'd6;

	localparam phase_t PH_RAS0  = 3'd0;
	localparam phase_t PH_CAS0  = PH_RAS0 + RASCAS_DELAY;
	localparam phase_t PH_RAS1  = 3'd3;                    // second ACTIVE after tRRD
	localparam phase_t PH_CAS1  = PH_RAS1 + RASCAS_DELAY;
	localparam phase_t PH_READ0 = 3'd0;                    // next frame
	localparam phase_t PH_READ1 = 3'd3;                    // next frame

	// single write, standard op, CL2, sequential, burst of one
	localparam sd_addr_t MODE_WORD = {3'b000, 1'b1, 2'b00, CAS_LATENCY, 1'b0, 3'b000};

	localparam logic [9:0] RFRSH_CYCLES = 10'd842;  // 64 ms / 8192 rows at 108 MHz

	// power-up countdown, in frames remaining
	localparam logic [4:0] INIT_FRAMES    = 5'd31;
	localparam logic [4:0] INIT_PRECHARGE = 5'd15;
	localparam logic [4:0] INIT_REFRESH_A = 5'd10;
	localparam logic [4:0] INIT_REFRESH_B = 5'd8;
	localparam logic [4:0] INIT_LOAD_MODE = 5'd2;

	// ------------------------------------------------------------
	// commands and structs
	// ------------------------------------------------------------
	typedef enum logic [3:0] {  // nCS nRAS nCAS nWE
		CMD_INHIBIT      = 4'b1111,
		CMD_NOP          = 4'b0111,
		CMD_ACTIVE       = 4'b0011,
		CMD_READ         = 4'b0101,
		CMD_WRITE        = 4'b0100,
		CMD_PRECHARGE    = 4'b0010,
		CMD_AUTO_REFRESH = 4'b0001,
		CMD_LOAD_MODE    = 4'b0000
	} sdram_cmd_e;

	typedef enum logic [1:0] {
		SRC_NONE   = 2'd0,
		SRC_STREAM = 2'd1,
		SRC_HOST   = 2'd2
	} src_e;

	typedef struct packed {
		logic       we;
		host_addr_t a;
		mask_t      ds;
		word_t      d;
	} host_req_t;

	typedef struct packed {
		sdram_cmd_e cmd;
		sd_addr_t   a;
		bank_t      ba;
		mask_t      dqm;    // active high masks, i.e. ~ds
		logic       dq_oe;
	} sdram_bus_t;

	typedef struct packed {
		src_e       src;
		full_addr_t addr;
	} pair_pick_t;

endpackage

/* source/sdram_port_select.sv */
// per bank pair client selector
// picks refresh hold, then a pending host request, then a changed
// stream address, and builds the full bank/row/column address

`timescale 1ns/10ps

module sdram_port_select #(
	parameter bit PAIR_BANK = 1'b0   // high bank bit: 0 = banks 0/1, 1 = banks 2/3
) (
	input  logic                    clk,
	input  logic                    init_n,
	input  sdram_pkg::phase_t       phase,
	input  sdram_pkg::host_req_t    host,
	input  logic                    host_pending,   // req differs from ack
	input  sdram_pkg::stream_addr_t stream_addr,
	input  logic                    hold,           // no access in this slot
	output sdram_pkg::pair_pick_t   pick
);

	// ras slot of this pair, the only phase where a pick is taken
	localparam sdram_pkg::phase_t RAS_SLOT =
		PAIR_BANK ? sdram_pkg::PH_RAS1 : sdram_pkg::PH_RAS0;

	sdram_pkg::stream_addr_t last_addr;      // stream address last read
	logic                    stream_changed;
	logic                    ras_slot;

	assign stream_changed = (stream_addr != last_addr);
	assign ras_slot       = (phase == RAS_SLOT);

	// ------------------------------------------------------------
	// priority choice
	// ------------------------------------------------------------
	always_comb begin
		pick.src  = sdram_pkg::SRC_NONE;
		pick.addr = {PAIR_BANK, 23'd0};       // don't care when idle
		if (!hold) begin
			if (host_pending) begin
				// host word address, bit 23 picks the bank within the pair
				pick.src  = sdram_pkg::SRC_HOST;
				pick.addr = {PAIR_BANK, host.a};
			end else if (stream_changed) begin
				// stream sits at the bottom of the pair's first bank
				pick.src  = sdram_pkg::SRC_STREAM;
				pick.addr = {PAIR_BANK, 8'd0, stream_addr};
			end
		end
	end

	// ------------------------------------------------------------
	// last stream address
	// ------------------------------------------------------------
	// updated only when the slot actually takes the stream read, so a
	// change during a host access or refresh is served later
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			last_addr <= '0;
		end else if (ras_slot && pick.src == sdram_pkg::SRC_STREAM) begin
			last_addr <= stream_addr;
		end
	end

endmodule

/* source/sdram_sequencer.sv */
// sdram frame sequencer
// runs the 6-cycle frame phase, the power-up frame countdown
// and the saturating refresh interval counter

`timescale 1ns/10ps

module sdram_sequencer (
	input  logic              clk,
	input  logic              init_n,
	output sdram_pkg::phase_t phase,
	output logic              init_busy,
	output logic [4:0]        init_frame,     // frames remaining until normal operation
	output logic              refresh_due,
	input  logic              refresh_taken   // AUTO REFRESH issued this cycle
);

	localparam sdram_pkg::phase_t LAST_PHASE = sdram_pkg::FRAME_LEN - 3'd1;

	logic       frame_end;
	logic [9:0] rfsh_cnt;   // cycles since last refresh, saturates

	assign frame_end   = (phase == LAST_PHASE);
	assign refresh_due = (rfsh_cnt == sdram_pkg::RFRSH_CYCLES);

	// ------------------------------------------------------------
	// frame phase and power-up countdown
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			phase      <= '0;
			init_frame <= sdram_pkg::INIT_FRAMES;
			init_busy  <= 1'b1;
		end else begin
			phase <= frame_end ? '0 : phase + 3'd1;
			if (frame_end && init_frame != 5'd0)
				init_frame <= init_frame - 5'd1;   // one step per frame
			init_busy <= (init_frame != 5'd0);     // drops one cycle after count hits 0
		end
	end

	// ------------------------------------------------------------
	// refresh interval
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			rfsh_cnt <= '0;
		end else if (refresh_taken) begin
			rfsh_cnt <= '0;                        // restart interval
		end else if (!refresh_due) begin
			rfsh_cnt <= rfsh_cnt + 10'd1;
		end
	end

endmodule

/* tb/sdram_model.sv */
// behavioural sdram for the controller testbench
// four banks with open-row tracking, CL2 reads, byte masks on writes,
// sparse storage and a log of every command seen on the pins

`timescale 1ns/10ps

module sdram_model (
	input  logic                  clk,
	input  sdram_pkg::sdram_bus_t bus,
	input  sdram_pkg::word_t      wdata,   // dq driven by the controller
	output sdram_pkg::word_t      rdata    // dq driven back
);

	sdram_pkg::word_t       mem [bit [23:0]];   // only written words are stored
	logic [12:0]            open_row [4];
	sdram_pkg::word_t       rd_pipe;            // first CL stage
	longint                 cycle;

	// command log, one entry per non-NOP command
	sdram_pkg::sdram_cmd_e  log_cmd [$];
	sdram_pkg::sd_addr_t    log_a   [$];
	longint                 log_cyc [$];

	// unwritten locations read back a pattern of the whole address
	function automatic sdram_pkg::word_t peek(input bit [23:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr[15:0] ^ {addr[23:16], 8'ha5};
	endfunction

	task automatic preload(input bit [23:0] addr, input sdram_pkg::word_t data);
		mem[addr] = data;
	endtask

	initial begin
		cycle   = 0;
		rdata   = '0;
		rd_pipe = '0;
		for (int b = 0; b < 4; b++)
			open_row[b] = '0;
	end

	// ------------------------------------------------------------
	// command decode
	// ------------------------------------------------------------
	always @(posedge clk) begin
		bit [23:0]        addr;
		sdram_pkg::word_t old;
		sdram_pkg::word_t din;
		addr  = {bus.ba, open_row[bus.ba], bus.a[8:0]};
		cycle <= cycle + 1;
		rdata <= rd_pipe;              // second stage, valid for the CL2 sample
		if (bus.cmd != sdram_pkg::CMD_NOP && bus.cmd != sdram_pkg::CMD_INHIBIT) begin
			log_cmd.push_back(bus.cmd);
			log_a.push_back(bus.a);
			log_cyc.push_back(cycle);
		end
		case (bus.cmd)
			sdram_pkg::CMD_ACTIVE:
				open_row[bus.ba] = bus.a;  // row
			sdram_pkg::CMD_READ:
				rd_pipe <= peek(addr);
			sdram_pkg::CMD_WRITE: begin
				old = peek(addr);
				din = bus.dq_oe ? wdata : 'x;   // undriven dq floats
				// dqm high keeps the stored byte
				mem[addr] = {bus.dqm[1] ? old[15:8] : din[15:8],
					bus.dqm[0] ? old[7:0] : din[7:0]};
			end
			default: ;
		endcase
	end

endmodule

/* tb/tb_sdram_ctrl.sv */
// sdram controller testbench
// directed tests for init order, host ports, byte masks, streams,
// refresh spacing and concurrent traffic against a behavioural sdram

`timescale 1ns/10ps

module tb_sdram_ctrl;

	localparam int FRAME            = 6;
	localparam int INIT_CYCLES      = (sdram_pkg::INIT_FRAMES + 2) * FRAME;
	localparam int IDLE_CYCLES      = 2000;
	localparam int NUM_TESTS        = 6;
	localparam int WATCHDOG_CYCLES  = INIT_CYCLES + NUM_TESTS * 40 * FRAME + IDLE_CYCLES;
	localparam int ACK_LIMIT        = 20;         // worst case is 12 plus a refresh slot
	localparam int STREAM_WAIT      = 3 * FRAME;
	localparam int BUSY_STREAM_WAIT = 25 * FRAME; // hosts win every slot of their pair

	logic                    clk;
	logic                    init_n;
	logic                    port1_req;
	logic                    port1_ack;
	sdram_pkg::host_req_t    port1_host;
	sdram_pkg::word_t        port1_q;
	logic                    port2_req;
	logic                    port2_ack;
	sdram_pkg::host_req_t    port2_host;
	sdram_pkg::word_t        port2_q;
	sdram_pkg::stream_addr_t cpu_addr;
	sdram_pkg::word_t        cpu_q;
	sdram_pkg::stream_addr_t gfx_addr;
	sdram_pkg::word_t        gfx_q;
	sdram_pkg::sdram_bus_t   sd_bus;
	sdram_pkg::word_t        dq_out;
	sdram_pkg::word_t        dq_in;

	int                      err_count;
	int                      check_count;
	logic [31:0]             lfsr_state;
	sdram_pkg::word_t        shadow [bit [23:0]];  // last word written per address

	sdram_ctrl u_sdram_ctrl (.*);

	sdram_model u_model (.clk(clk), .bus(sd_bus), .wdata(dq_out), .rdata(dq_in));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (exp !== act) begin
			err_count++;
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic        fb;
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v          = {v[30:0], fb};
		end
		return v;
	endfunction

	// one toggle handshake on host port 1 or 2
	task automatic host_access(input int port, input logic we, input sdram_pkg::host_addr_t a,
		input sdram_pkg::mask_t ds, input sdram_pkg::word_t d, output sdram_pkg::word_t q);
		int   waited;
		logic done;
		waited = 0;
		@(negedge clk);
		check_count++;
		if ((port == 1 ? port1_ack ^ port1_req : port2_ack ^ port2_req) !== 1'b0) begin
			err_count++;
			$display("port %0d ack toggled with no request pending at %0t", port, $time);
		end
		if (port == 1) begin
			port1_host = '{we: we, a: a, ds: ds, d: d};
			port1_req  = ~port1_req;
		end else begin
			port2_host = '{we: we, a: a, ds: ds, d: d};
			port2_req  = ~port2_req;
		end
		do begin
			@(negedge clk);
			waited++;
			done = (port == 1) ? (port1_ack === port1_req) : (port2_ack === port2_req);
		end while (!done && waited < ACK_LIMIT);
		check_count++;
		if (!done) begin
			err_count++;
			$display("port %0d request lost, no ack after %0d cycles at %0t", port, waited, $time);
		end
		q = (port == 1) ? port1_q : port2_q;
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_init();
		check_count++;
		if (u_model.log_cmd.size() < 4) begin
			err_count++;
			$display("only %0d commands seen on the pins by the end of init",
				u_model.log_cmd.size());
		end else begin
			// both streams were waiting through init, an early ACTIVE lands in here
			check_eq("log_cmd[0]", 32'(sdram_pkg::CMD_PRECHARGE), 32'(u_model.log_cmd[0]));
			check_eq("log_a[0][10]", 1, 32'(u_model.log_a[0][10]));
			check_eq("log_cmd[1]", 32'(sdram_pkg::CMD_AUTO_REFRESH), 32'(u_model.log_cmd[1]));
			check_eq("log_cmd[2]", 32'(sdram_pkg::CMD_AUTO_REFRESH), 32'(u_model.log_cmd[2]));
			check_eq("log_cmd[3]", 32'(sdram_pkg::CMD_LOAD_MODE), 32'(u_model.log_cmd[3]));
			check_eq("log_a[3]", 32'(13'b000_1_00_010_0_000), 32'(u_model.log_a[3]));
		end
	endtask

	// writes a batch then reads it back, pair 0 or pair 1 by port
	task automatic port_traffic(input int port, input int n, input logic upper_bank);
		sdram_pkg::host_addr_t addr [8];
		logic [31:0]           r;
		sdram_pkg::word_t      q;
		bit [23:0]             key;
		for (int i = 0; i < n; i++) begin
			r       = rand_bits(23);
			addr[i] = r[22:0];
			if (upper_bank)
				addr[i][23] = 1'b1;        // clear of the stream area
			r = rand_bits(16);
			host_access(port, 1'b1, addr[i], 2'b11, r[15:0], q);
			shadow[{port == 2, addr[i]}] = r[15:0];
		end
		for (int i = 0; i < n; i++) begin
			key = {port == 2, addr[i]};
			host_access(port, 1'b0, addr[i], 2'b11, 16'h0, q);
			check_eq($sformatf("port%0d_q", port), 32'(shadow[key]), 32'(q));
		end
	endtask

	task automatic test_byte_mask();
		logic [31:0]      r;
		logic [31:0]      d1;
		logic [31:0]      d2;
		sdram_pkg::word_t q;
		sdram_pkg::word_t merged;
		sdram_pkg::mask_t ds;
		for (int i = 0; i < 2; i++) begin
			ds = (i == 0) ? 2'b01 : 2'b10;  // lower byte, then upper byte
			r  = rand_bits(23);
			d1 = rand_bits(16);
			d2 = rand_bits(16);
			host_access(2, 1'b1, r[22:0], 2'b11, d1[15:0], q);
			host_access(2, 1'b1, r[22:0], ds, d2[15:0], q);
			host_access(2, 1'b0, r[22:0], 2'b11, 16'h0, q);
			merged = ds[0] ? {d1[15:8], d2[7:0]} : {d2[15:8], d1[7:0]};
			check_eq("port2_q", 32'(merged), 32'(q));
		end
	endtask

	// preloads one word per stream, moves both addresses and waits for both words
	task automatic stream_read(input sdram_pkg::stream_addr_t cs,
		input sdram_pkg::stream_addr_t gs, input int limit);
		logic [31:0] cw;
		logic [31:0] gw;
		int          waited;
		cw = rand_bits(16);
		gw = rand_bits(16);
		if (cs == cpu_addr)
			cs = ~cs;                        // must look like a change
		if (gs == gfx_addr)
			gs = ~gs;
		u_model.preload({1'b0, 8'd0, cs}, cw[15:0]);
		u_model.preload({1'b1, 8'd0, gs}, gw[15:0]);
		@(negedge clk);
		cpu_addr = cs;
		gfx_addr = gs;
		waited   = 0;
		do begin
			@(negedge clk);
			waited++;
		end while ((cpu_q !== cw[15:0] || gfx_q !== gw[15:0]) && waited < limit);
		check_eq("cpu_q", cw, 32'(cpu_q));
		check_eq("gfx_q", gw, 32'(gfx_q));
	endtask

	task automatic test_streams(input int n, input int limit);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = rand_bits(30);
			stream_read(r[14:0], r[29:15], limit);
		end
	endtask

	task automatic test_refresh();
		int     base;
		int     n_ref;
		longint last;
		base  = u_model.log_cmd.size();
		n_ref = 0;
		last  = 0;
		repeat (IDLE_CYCLES) @(negedge clk);
		for (int i = base; i < u_model.log_cmd.size(); i++) begin
			if (u_model.log_cmd[i] == sdram_pkg::CMD_AUTO_REFRESH) begin
				check_count++;
				if (n_ref > 0 && u_model.log_cyc[i] - last < 842) begin
					err_count++;
					$display("refresh only %0d cycles after the previous one at %0t",
						u_model.log_cyc[i] - last, $time);
				end
				last = u_model.log_cyc[i];
				n_ref++;
			end
		end
		check_count++;
		if (n_ref < 2) begin
			err_count++;
			$display("only %0d refresh commands in %0d idle cycles", n_ref, IDLE_CYCLES);
		end
	endtask

	task automatic test_concurrency();
		fork
			port_traffic(1, 5, 1'b1);
			port_traffic(2, 5, 1'b1);
			test_streams(4, BUSY_STREAM_WAIT);
		join
	endtask

	// ------------------------------------------------------------
	// main sequence and watchdog
	// ------------------------------------------------------------
	initial begin
		logic [31:0] r;
		err_count   = 0;
		check_count = 0;
		lfsr_state  = 32'h6f3c;
		init_n      = 1'b1;
		port1_req   = 1'b0;
		port2_req   = 1'b0;
		port1_host  = '0;
		port2_host  = '0;
		cpu_addr    = '0;
		gfx_addr    = '0;
		#1 init_n   = 1'b0;   // a real falling edge resets the flops
		repeat (5) @(negedge clk);
		init_n   = 1'b1;
		r        = rand_bits(30);
		cpu_addr = r[14:0] | 15'd1;   // stream reads pending for the whole init
		gfx_addr = r[29:15] | 15'd1;
		repeat (INIT_CYCLES) @(negedge clk);
		test_init();
		port_traffic(1, 8, 1'b0);
		test_byte_mask();
		test_streams(3, STREAM_WAIT);
		test_refresh();
		test_concurrency();
		$display("checks %0d errors %0d", check_count, err_count);
		if (err_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("checks %0d errors %0d", check_count, err_count);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule
